// File: source/cas_pkg.sv
// ***********************************************************
// CAS subsystem package.
// Bus widths, CAS register window, engine states, RAM size.
// ***********************************************************
package cas_pkg;

   localparam int ADDR_W    = 32;             // Wishbone address width.
   localparam int DATA_W    = 32;             // Wishbone data width.
   localparam int SEL_W     = DATA_W / 8;     // One select per byte.
   localparam int RAM_WORDS = 256;            // Shared RAM depth.

   // Upper address bits 31:8 of the CAS register window.
   localparam logic [23:0] CAS_BASE = 24'hF00000;

   // Register offsets inside the window, taken from address bits 3:0.
   typedef enum logic [3:0] {
      REG_ADDR   = 4'h0,                      // Target word address.
      REG_CMP    = 4'h4,                      // Compare value.
      REG_SWAP   = 4'h8,                      // Swap value.
      REG_RESULT = 4'hC                       // Read starts the CAS.
   } cas_reg_e;

   typedef enum logic [2:0] {
      ST_IDLE,                                // Serving register accesses.
      ST_READ,                                // Locked read of target.
      ST_CMP,                                 // Old word against compare.
      ST_WRITE,                               // Swap write, cyc still held.
      ST_DONE                                 // Respond to the core.
   } cas_state_e;

endpackage

// File: source/wb_cas_fsm.sv
`timescale 1ns/100ps
// ***********************************************************
// CAS engine.
// Holds the address, compare and swap registers and runs the
// locked read, compare and conditional write on the bus.
// ***********************************************************
module wb_cas_fsm (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [cas_pkg::ADDR_W-1:0] core_adr_i,
   input  logic [cas_pkg::DATA_W-1:0] core_dat_i,
   input  logic [cas_pkg::SEL_W-1:0]  core_sel_i,
   input  logic                       core_we_i,
   input  logic                       core_stb_i,
   output logic [cas_pkg::DATA_W-1:0] core_dat_o,
   output logic                       core_ack_o,
   output logic                       core_err_o,
   output logic [cas_pkg::ADDR_W-1:0] bus_adr_o,
   output logic [cas_pkg::DATA_W-1:0] bus_dat_o,
   output logic [cas_pkg::SEL_W-1:0]  bus_sel_o,
   output logic                       bus_we_o,
   output logic                       bus_cyc_o,
   output logic                       bus_stb_o,
   input  logic [cas_pkg::DATA_W-1:0] bus_dat_i,
   input  logic                       bus_ack_i,
   input  logic                       bus_err_i
);
   import cas_pkg::*;

   cas_state_e        state_q;                // Engine state.
   cas_reg_e          reg_sel;                // Offset of the core access.
   logic [ADDR_W-1:0] addr_q;                 // Target address.
   logic [DATA_W-1:0] cmp_q;                  // Compare value.
   logic [DATA_W-1:0] swap_q;                 // Swap value.
   logic [DATA_W-1:0] old_q;                  // Word read from target.
   logic [DATA_W-1:0] wmask;                  // Byte selects as bit mask.
   logic              reg_ack_q;              // Register access response.
   logic              err_q;                  // Bus error seen in sequence.
   logic              req;                    // Fresh core access.
   logic              start;                  // Result read kicks engine.

   assign reg_sel = cas_reg_e'(core_adr_i[3:0]);
   assign req     = core_stb_i && !reg_ack_q && (state_q == ST_IDLE);
   assign start   = req && !core_we_i && (reg_sel == REG_RESULT);

   always_comb begin
      for (int b = 0; b < SEL_W; b++) begin
         wmask[8*b +: 8] = {8{core_sel_i[b]}};
      end
   end

   // Register file and captured old word.
   always_ff @(posedge clk_i) begin
      if (req && core_we_i) begin
         case (reg_sel)
            REG_ADDR: addr_q <= (addr_q & ~wmask) | (core_dat_i & wmask);
            REG_CMP:  cmp_q  <= (cmp_q & ~wmask) | (core_dat_i & wmask);
            REG_SWAP: swap_q <= (swap_q & ~wmask) | (core_dat_i & wmask);
            default: ;                        // Result is read only.
         endcase
      end
      if ((state_q == ST_READ) && bus_ack_i) begin
         old_q <= bus_dat_i;                  // Value returned to core.
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_IDLE;
         reg_ack_q <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         reg_ack_q <= req && !start;          // One cycle after stb.
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  err_q   <= 1'b0;
                  state_q <= ST_READ;
               end
            end
            ST_READ: begin
               if (bus_err_i) begin
                  err_q   <= 1'b1;
                  state_q <= ST_DONE;         // Nothing to compare.
               end else if (bus_ack_i) begin
                  state_q <= ST_CMP;
               end
            end
            ST_CMP: begin
               // Mismatch skips the write.
               state_q <= (old_q == cmp_q) ? ST_WRITE : ST_DONE;
            end
            ST_WRITE: begin
               if (bus_err_i) begin
                  err_q   <= 1'b1;
                  state_q <= ST_DONE;
               end else if (bus_ack_i) begin
                  state_q <= ST_DONE;
               end
            end
            ST_DONE: state_q <= ST_IDLE;      // Core drops stb now.
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_comb begin
      case (reg_sel)
         REG_ADDR:   core_dat_o = addr_q;
         REG_CMP:    core_dat_o = cmp_q;
         REG_SWAP:   core_dat_o = swap_q;
         REG_RESULT: core_dat_o = old_q;
         default:    core_dat_o = '0;         // Hole in the window.
      endcase
   end

   assign core_ack_o = reg_ack_q || ((state_q == ST_DONE) && !err_q);
   assign core_err_o = (state_q == ST_DONE) && err_q;

   assign bus_adr_o = addr_q;
   assign bus_dat_o = swap_q;
   assign bus_sel_o = '1;                     // Whole word always.
   assign bus_we_o  = (state_q == ST_WRITE);
   assign bus_stb_o = (state_q == ST_READ) || (state_q == ST_WRITE);
   // Held through compare so the arbiter keeps the grant.
   assign bus_cyc_o = (state_q == ST_READ) || (state_q == ST_CMP) || (state_q == ST_WRITE);

   // Bus lock must not break between the read and the response.
   a_cyc_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q == ST_READ) |-> (bus_cyc_o until (state_q == ST_DONE)));

endmodule

// File: source/wb_cas_unit.sv
`timescale 1ns/100ps
// ***********************************************************
// Per-core CAS unit.
// Plain accesses pass to the bus, the CAS window goes to the
// engine, which then owns both the core and the bus side.
// ***********************************************************
module wb_cas_unit (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [cas_pkg::ADDR_W-1:0] core_adr_i,
   input  logic [cas_pkg::DATA_W-1:0] core_dat_i,
   input  logic [cas_pkg::SEL_W-1:0]  core_sel_i,
   input  logic                       core_we_i,
   input  logic                       core_cyc_i,
   input  logic                       core_stb_i,
   output logic [cas_pkg::DATA_W-1:0] core_dat_o,
   output logic                       core_ack_o,
   output logic                       core_err_o,
   output logic [cas_pkg::ADDR_W-1:0] bus_adr_o,
   output logic [cas_pkg::DATA_W-1:0] bus_dat_o,
   output logic [cas_pkg::SEL_W-1:0]  bus_sel_o,
   output logic                       bus_we_o,
   output logic                       bus_cyc_o,
   output logic                       bus_stb_o,
   input  logic [cas_pkg::DATA_W-1:0] bus_dat_i,
   input  logic                       bus_ack_i,
   input  logic                       bus_err_i
);
   import cas_pkg::*;

   logic              bypass;                 // Outside the CAS window.
   logic              fsm_stb;
   logic [DATA_W-1:0] fsm_core_dat;
   logic              fsm_core_ack;
   logic              fsm_core_err;
   logic [ADDR_W-1:0] fsm_bus_adr;
   logic [DATA_W-1:0] fsm_bus_dat;
   logic [SEL_W-1:0]  fsm_bus_sel;
   logic              fsm_bus_we;
   logic              fsm_bus_cyc;
   logic              fsm_bus_stb;

   assign bypass  = (core_adr_i[ADDR_W-1:8] != CAS_BASE);
   assign fsm_stb = !bypass && core_cyc_i && core_stb_i;

   wb_cas_fsm cas_fsm (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_adr_i (core_adr_i),
      .core_dat_i (core_dat_i),
      .core_sel_i (core_sel_i),
      .core_we_i  (core_we_i),
      .core_stb_i (fsm_stb),
      .core_dat_o (fsm_core_dat),
      .core_ack_o (fsm_core_ack),
      .core_err_o (fsm_core_err),
      .bus_adr_o  (fsm_bus_adr),
      .bus_dat_o  (fsm_bus_dat),
      .bus_sel_o  (fsm_bus_sel),
      .bus_we_o   (fsm_bus_we),
      .bus_cyc_o  (fsm_bus_cyc),
      .bus_stb_o  (fsm_bus_stb),
      .bus_dat_i  (bus_dat_i),
      .bus_ack_i  (!bypass && bus_ack_i),     // Engine sees only its own.
      .bus_err_i  (!bypass && bus_err_i)
   );

   assign core_dat_o = bypass ? bus_dat_i : fsm_core_dat;
   assign core_ack_o = bypass ? bus_ack_i : fsm_core_ack;
   assign core_err_o = bypass ? bus_err_i : fsm_core_err;

   assign bus_adr_o = bypass ? core_adr_i : fsm_bus_adr;
   assign bus_dat_o = bypass ? core_dat_i : fsm_bus_dat;
   assign bus_sel_o = bypass ? core_sel_i : fsm_bus_sel;
   assign bus_we_o  = bypass ? core_we_i  : fsm_bus_we;
   assign bus_cyc_o = bypass ? core_cyc_i : fsm_bus_cyc;
   assign bus_stb_o = bypass ? core_stb_i : fsm_bus_stb;

endmodule

// File: source/wb_arbiter.sv
`timescale 1ns/100ps
// ***********************************************************
// Two-master Wishbone arbiter.
// Registered round-robin grant, held while the owner keeps cyc.
// ***********************************************************
module wb_arbiter (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [cas_pkg::ADDR_W-1:0] m0_adr_i,
   input  logic [cas_pkg::DATA_W-1:0] m0_dat_w_i,
   input  logic [cas_pkg::SEL_W-1:0]  m0_sel_i,
   input  logic                       m0_we_i,
   input  logic                       m0_cyc_i,
   input  logic                       m0_stb_i,
   output logic [cas_pkg::DATA_W-1:0] m0_dat_r_o,
   output logic                       m0_ack_o,
   output logic                       m0_err_o,
   input  logic [cas_pkg::ADDR_W-1:0] m1_adr_i,
   input  logic [cas_pkg::DATA_W-1:0] m1_dat_w_i,
   input  logic [cas_pkg::SEL_W-1:0]  m1_sel_i,
   input  logic                       m1_we_i,
   input  logic                       m1_cyc_i,
   input  logic                       m1_stb_i,
   output logic [cas_pkg::DATA_W-1:0] m1_dat_r_o,
   output logic                       m1_ack_o,
   output logic                       m1_err_o,
   output logic [cas_pkg::ADDR_W-1:0] s_adr_o,
   output logic [cas_pkg::DATA_W-1:0] s_dat_w_o,
   output logic [cas_pkg::SEL_W-1:0]  s_sel_o,
   output logic                       s_we_o,
   output logic                       s_stb_o,
   input  logic [cas_pkg::DATA_W-1:0] s_dat_r_i,
   input  logic                       s_ack_i,
   input  logic                       s_err_i
);
   logic [1:0] gnt_q;                         // One bit per master.
   logic       last_q;                        // Last winner, 1 for m1.
   logic       owner_cyc;                     // Current owner still locks.

   assign owner_cyc = (gnt_q[0] && m0_cyc_i) || (gnt_q[1] && m1_cyc_i);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         gnt_q  <= 2'b00;
         last_q <= 1'b1;                      // m0 goes first.
      end else if (!owner_cyc) begin
         if (m0_cyc_i && (!m1_cyc_i || last_q)) begin
            gnt_q  <= 2'b01;
            last_q <= 1'b0;
         end else if (m1_cyc_i) begin
            gnt_q  <= 2'b10;
            last_q <= 1'b1;
         end else begin
            gnt_q  <= 2'b00;                  // Bus parked.
         end
      end
   end

   always_comb begin
      if (gnt_q[1]) begin
         s_adr_o   = m1_adr_i;
         s_dat_w_o = m1_dat_w_i;
         s_sel_o   = m1_sel_i;
         s_we_o    = m1_we_i;
         s_stb_o   = m1_cyc_i && m1_stb_i;
      end else begin
         s_adr_o   = m0_adr_i;
         s_dat_w_o = m0_dat_w_i;
         s_sel_o   = m0_sel_i;
         s_we_o    = m0_we_i;
         s_stb_o   = gnt_q[0] && m0_cyc_i && m0_stb_i;
      end
   end

   // Responses reach the owner only. Others wait.
   assign m0_dat_r_o = s_dat_r_i;
   assign m0_ack_o   = gnt_q[0] && s_ack_i;
   assign m0_err_o   = gnt_q[0] && s_err_i;
   assign m1_dat_r_o = s_dat_r_i;
   assign m1_ack_o   = gnt_q[1] && s_ack_i;
   assign m1_err_o   = gnt_q[1] && s_err_i;

   a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(gnt_q[0] && gnt_q[1]));

endmodule

// File: source/wb_ram.sv
`timescale 1ns/100ps
// ***********************************************************
// Shared RAM slave.
// Word memory with byte selects and a one-cycle registered
// response, err for addresses beyond the array.
// ***********************************************************
module wb_ram (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [cas_pkg::ADDR_W-1:0] adr_i,
   input  logic [cas_pkg::DATA_W-1:0] dat_i,
   input  logic [cas_pkg::SEL_W-1:0]  sel_i,
   input  logic                       we_i,
   input  logic                       stb_i,
   output logic [cas_pkg::DATA_W-1:0] dat_o,
   output logic                       ack_o,
   output logic                       err_o
);
   import cas_pkg::*;

   logic [DATA_W-1:0]              mem [RAM_WORDS];
   logic [DATA_W-1:0]              dat_q;     // Read word, valid with ack.
   logic [$clog2(RAM_WORDS)-1:0]   idx;       // Word index, bits 9:2.
   logic                           out_of_range;
   logic                           req;       // New access this cycle.
   logic                           ack_q;
   logic                           err_q;

   assign idx          = adr_i[$clog2(RAM_WORDS)+1:2];
   assign out_of_range = |adr_i[ADDR_W-1:$clog2(RAM_WORDS)+2];
   assign req          = stb_i && !ack_q && !err_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req && !out_of_range;
         err_q <= req && out_of_range;        // No array access.
      end
   end

   always_ff @(posedge clk_i) begin
      if (req && !out_of_range) begin
         if (we_i) begin
            for (int b = 0; b < SEL_W; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end
         dat_q <= mem[idx];
      end
   end

   assign dat_o = dat_q;
   assign ack_o = ack_q;
   assign err_o = err_q;

   a_resp_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(ack_o && err_o));

endmodule

// File: source/cas_smp_top.sv
`timescale 1ns/100ps
// ***********************************************************
// Two-core CAS subsystem.
// Two CAS units share one RAM through the arbiter.
// ***********************************************************
module cas_smp_top (
   input  logic                       clk_i,
   input  logic                       rst_n_i,
   input  logic [cas_pkg::ADDR_W-1:0] core0_adr_i,
   input  logic [cas_pkg::DATA_W-1:0] core0_dat_i,
   input  logic [cas_pkg::SEL_W-1:0]  core0_sel_i,
   input  logic                       core0_we_i,
   input  logic                       core0_cyc_i,
   input  logic                       core0_stb_i,
   output logic [cas_pkg::DATA_W-1:0] core0_dat_o,
   output logic                       core0_ack_o,
   output logic                       core0_err_o,
   input  logic [cas_pkg::ADDR_W-1:0] core1_adr_i,
   input  logic [cas_pkg::DATA_W-1:0] core1_dat_i,
   input  logic [cas_pkg::SEL_W-1:0]  core1_sel_i,
   input  logic                       core1_we_i,
   input  logic                       core1_cyc_i,
   input  logic                       core1_stb_i,
   output logic [cas_pkg::DATA_W-1:0] core1_dat_o,
   output logic                       core1_ack_o,
   output logic                       core1_err_o
);
   import cas_pkg::*;

   logic [ADDR_W-1:0] m0_adr, m1_adr, s_adr;
   logic [DATA_W-1:0] m0_dat_w, m1_dat_w, s_dat_w;
   logic [DATA_W-1:0] m0_dat_r, m1_dat_r, s_dat_r;
   logic [SEL_W-1:0]  m0_sel, m1_sel, s_sel;
   logic              m0_we, m0_cyc, m0_stb, m0_ack, m0_err;
   logic              m1_we, m1_cyc, m1_stb, m1_ack, m1_err;
   logic              s_we, s_stb, s_ack, s_err;

   wb_cas_unit cas_unit0 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_adr_i (core0_adr_i),
      .core_dat_i (core0_dat_i),
      .core_sel_i (core0_sel_i),
      .core_we_i  (core0_we_i),
      .core_cyc_i (core0_cyc_i),
      .core_stb_i (core0_stb_i),
      .core_dat_o (core0_dat_o),
      .core_ack_o (core0_ack_o),
      .core_err_o (core0_err_o),
      .bus_adr_o  (m0_adr),
      .bus_dat_o  (m0_dat_w),
      .bus_sel_o  (m0_sel),
      .bus_we_o   (m0_we),
      .bus_cyc_o  (m0_cyc),
      .bus_stb_o  (m0_stb),
      .bus_dat_i  (m0_dat_r),
      .bus_ack_i  (m0_ack),
      .bus_err_i  (m0_err)
   );

   wb_cas_unit cas_unit1 (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .core_adr_i (core1_adr_i),
      .core_dat_i (core1_dat_i),
      .core_sel_i (core1_sel_i),
      .core_we_i  (core1_we_i),
      .core_cyc_i (core1_cyc_i),
      .core_stb_i (core1_stb_i),
      .core_dat_o (core1_dat_o),
      .core_ack_o (core1_ack_o),
      .core_err_o (core1_err_o),
      .bus_adr_o  (m1_adr),
      .bus_dat_o  (m1_dat_w),
      .bus_sel_o  (m1_sel),
      .bus_we_o   (m1_we),
      .bus_cyc_o  (m1_cyc),
      .bus_stb_o  (m1_stb),
      .bus_dat_i  (m1_dat_r),
      .bus_ack_i  (m1_ack),
      .bus_err_i  (m1_err)
   );

   wb_arbiter arbiter (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .m0_adr_i   (m0_adr),
      .m0_dat_w_i (m0_dat_w),
      .m0_sel_i   (m0_sel),
      .m0_we_i    (m0_we),
      .m0_cyc_i   (m0_cyc),
      .m0_stb_i   (m0_stb),
      .m0_dat_r_o (m0_dat_r),
      .m0_ack_o   (m0_ack),
      .m0_err_o   (m0_err),
      .m1_adr_i   (m1_adr),
      .m1_dat_w_i (m1_dat_w),
      .m1_sel_i   (m1_sel),
      .m1_we_i    (m1_we),
      .m1_cyc_i   (m1_cyc),
      .m1_stb_i   (m1_stb),
      .m1_dat_r_o (m1_dat_r),
      .m1_ack_o   (m1_ack),
      .m1_err_o   (m1_err),
      .s_adr_o    (s_adr),
      .s_dat_w_o  (s_dat_w),
      .s_sel_o    (s_sel),
      .s_we_o     (s_we),
      .s_stb_o    (s_stb),
      .s_dat_r_i  (s_dat_r),
      .s_ack_i    (s_ack),
      .s_err_i    (s_err)
   );

   wb_ram ram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .adr_i   (s_adr),
      .dat_i   (s_dat_w),
      .sel_i   (s_sel),
      .we_i    (s_we),
      .stb_i   (s_stb),
      .dat_o   (s_dat_r),
      .ack_o   (s_ack),
      .err_o   (s_err)
   );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/100ps
// ***********************************************************
// Testbench clock source.
// Free-running clock, 20 ns period by default.
// ***********************************************************
module tb_clkgen #(
   parameter int PERIOD = 20                  // Clock period in ns.
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;                           // Known level at time zero.
      forever begin
         #(PERIOD / 2);
         clk_o = ~clk_o;
      end
   end

endmodule

// File: tb/tb_cas_smp.sv
`timescale 1ns/100ps
// ***********************************************************
// Testbench for the two-core CAS subsystem.
// Applies a table of plain, CAS and concurrent accesses and
// checks every response against a reference memory.
// ***********************************************************
module tb_cas_smp;
   import cas_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 5;
   localparam int MAX_ROWS   = 32;
   localparam int ROW_CYCLES = 200;           // Watchdog budget per row.
   localparam int LOOP_READS = 8;             // Core 1 reads during a CAS.

   typedef enum {OP_WR, OP_RD, OP_CAS, OP_DUAL_CAS, OP_CAS_RD_LOOP} op_e;

   logic              clk;
   logic              rst_n;
   logic [ADDR_W-1:0] core0_adr, core1_adr;
   logic [DATA_W-1:0] core0_dat_w, core1_dat_w;
   logic [DATA_W-1:0] core0_dat_r, core1_dat_r;
   logic [SEL_W-1:0]  core0_sel, core1_sel;
   logic              core0_we, core0_cyc, core0_stb, core0_ack, core0_err;
   logic              core1_we, core1_cyc, core1_stb, core1_ack, core1_err;

   int                row_core [MAX_ROWS];    // Issuing core.
   op_e               row_op   [MAX_ROWS];
   logic [ADDR_W-1:0] row_adr  [MAX_ROWS];
   logic [DATA_W-1:0] row_dat  [MAX_ROWS];    // Write data or swap value.
   logic [SEL_W-1:0]  row_sel  [MAX_ROWS];
   logic [DATA_W-1:0] row_cmp  [MAX_ROWS];
   logic              row_err  [MAX_ROWS];    // Error response expected.
   int                n_rows = 0;
   logic              table_ready = 1'b0;
   int                error_count = 0;
   logic [DATA_W-1:0] ref_mem  [RAM_WORDS];   // Expected RAM contents.

   tb_clkgen #(.PERIOD(CLK_PERIOD)) clkgen_inst (.clk_o(clk));

   cas_smp_top cas_smp_top_inst (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .core0_adr_i (core0_adr),
      .core0_dat_i (core0_dat_w),
      .core0_sel_i (core0_sel),
      .core0_we_i  (core0_we),
      .core0_cyc_i (core0_cyc),
      .core0_stb_i (core0_stb),
      .core0_dat_o (core0_dat_r),
      .core0_ack_o (core0_ack),
      .core0_err_o (core0_err),
      .core1_adr_i (core1_adr),
      .core1_dat_i (core1_dat_w),
      .core1_sel_i (core1_sel),
      .core1_we_i  (core1_we),
      .core1_cyc_i (core1_cyc),
      .core1_stb_i (core1_stb),
      .core1_dat_o (core1_dat_r),
      .core1_ack_o (core1_ack),
      .core1_err_o (core1_err)
   );

   task automatic report_failure();
      error_count++;
      $display("TESTS FAILED");
      $fatal(1, "Run stopped at the first error.");
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] got);
      assert (got === exp) else begin
         $display("[ERROR] %s: expected %h, got %h", name, exp, got);
         report_failure();
      end
   endtask

   task automatic check_flag(input int core, input logic exp, input logic got);
      assert (got === exp) else begin
         $display("[ERROR] core%0d_err_o: expected %h, got %h", core, exp, got);
         report_failure();
      end
   endtask

   function automatic string dat_name(input int core);
      return $sformatf("core%0d_dat_o", core);
   endfunction

   // RAM word index from address bits 9:2.
   function automatic int word_idx(input logic [ADDR_W-1:0] adr);
      return int'(adr[9:2]);
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                     input logic [DATA_W-1:0] new_w,
                                                     input logic [SEL_W-1:0]  sel);
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];  // Selected lanes only.
      end
      return res;
   endfunction

   function automatic logic [ADDR_W-1:0] win_adr(input cas_reg_e off);
      return {CAS_BASE, 4'h0, off};
   endfunction

   // Single classic access on core 0, ended by ack or err.
   task automatic core0_xfer(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                             input logic [SEL_W-1:0] sel, input logic we,
                             output logic [DATA_W-1:0] rdat, output logic err);
      @(negedge clk);
      core0_adr   = adr;
      core0_dat_w = dat;
      core0_sel   = sel;
      core0_we    = we;
      core0_cyc   = 1'b1;
      core0_stb   = 1'b1;
      @(negedge clk);
      while (!core0_ack && !core0_err) @(negedge clk);  // Mid-cycle sample.
      rdat      = core0_dat_r;
      err       = core0_err;
      core0_cyc = 1'b0;
      core0_stb = 1'b0;
      core0_we  = 1'b0;
   endtask

   task automatic core1_xfer(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                             input logic [SEL_W-1:0] sel, input logic we,
                             output logic [DATA_W-1:0] rdat, output logic err);
      @(negedge clk);
      core1_adr   = adr;
      core1_dat_w = dat;
      core1_sel   = sel;
      core1_we    = we;
      core1_cyc   = 1'b1;
      core1_stb   = 1'b1;
      @(negedge clk);
      while (!core1_ack && !core1_err) @(negedge clk);
      rdat      = core1_dat_r;
      err       = core1_err;
      core1_cyc = 1'b0;
      core1_stb = 1'b0;
      core1_we  = 1'b0;
   endtask

   task automatic xfer(input int core, input logic [ADDR_W-1:0] adr,
                       input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                       input logic we, output logic [DATA_W-1:0] rdat, output logic err);
      if (core == 0) core0_xfer(adr, dat, sel, we, rdat, err);
      else core1_xfer(adr, dat, sel, we, rdat, err);
   endtask

   // Load the three registers, then the result read runs the CAS.
   task automatic run_cas(input int core, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] cmp, input logic [DATA_W-1:0] swap,
                          output logic [DATA_W-1:0] old_w, output logic err);
      logic [DATA_W-1:0] unused;
      logic              reg_err;
      xfer(core, win_adr(REG_ADDR), adr, '1, 1'b1, unused, reg_err);
      check_flag(core, 1'b0, reg_err);
      xfer(core, win_adr(REG_CMP), cmp, '1, 1'b1, unused, reg_err);
      check_flag(core, 1'b0, reg_err);
      xfer(core, win_adr(REG_SWAP), swap, '1, 1'b1, unused, reg_err);
      check_flag(core, 1'b0, reg_err);
      xfer(core, win_adr(REG_RESULT), '0, '1, 1'b0, old_w, err);
   endtask

   // Both cores race on one word holding the compare value.
   task automatic dual_cas(input int i);
      logic [DATA_W-1:0] old0, old1, swap0, swap1, final_w;
      logic              err0, err1;
      int                idx;
      idx   = word_idx(row_adr[i]);
      swap0 = row_dat[i];
      swap1 = ~row_dat[i];                    // Distinct swap per core.
      fork
         run_cas(0, row_adr[i], row_cmp[i], swap0, old0, err0);
         run_cas(1, row_adr[i], row_cmp[i], swap1, old1, err1);
      join
      check_flag(0, 1'b0, err0);
      check_flag(1, 1'b0, err1);
      assert ((old0 == row_cmp[i]) != (old1 == row_cmp[i])) else begin
         $display("[ERROR] core0_dat_o/core1_dat_o: expected one match of %h, got %h and %h",
                  row_cmp[i], old0, old1);
         report_failure();
      end
      // Loser must see the winner's swap value.
      if (old0 == row_cmp[i]) begin
         check_word("core1_dat_o", swap0, old1);
         ref_mem[idx] = swap0;
      end else begin
         check_word("core0_dat_o", swap1, old0);
         ref_mem[idx] = swap1;
      end
      core0_xfer(row_adr[i], '0, '1, 1'b0, final_w, err0);
      check_flag(0, 1'b0, err0);
      check_word("core0_dat_o", ref_mem[idx], final_w);
   endtask

   // Core 0 CAS while core 1 keeps reading the next word.
   task automatic cas_under_reads(input int i);
      logic [DATA_W-1:0] old_w;
      logic              err;
      int                idx, nb;
      idx = word_idx(row_adr[i]);
      nb  = (idx + 1) % RAM_WORDS;
      fork
         run_cas(0, row_adr[i], row_cmp[i], row_dat[i], old_w, err);
         begin
            logic [DATA_W-1:0] rd;
            logic              rd_err;
            for (int k = 0; k < LOOP_READS; k++) begin
               core1_xfer(row_adr[i] + 4, '0, '1, 1'b0, rd, rd_err);
               check_flag(1, 1'b0, rd_err);
               check_word("core1_dat_o", ref_mem[nb], rd);
            end
         end
      join
      check_flag(0, 1'b0, err);
      check_word("core0_dat_o", ref_mem[idx], old_w);
      if (ref_mem[idx] == row_cmp[i]) ref_mem[idx] = row_dat[i];
   endtask

   task automatic apply_row(input int i);
      logic [DATA_W-1:0] got;
      logic              err;
      int                idx;
      idx = word_idx(row_adr[i]);
      case (row_op[i])
         OP_WR: begin
            xfer(row_core[i], row_adr[i], row_dat[i], row_sel[i], 1'b1, got, err);
            check_flag(row_core[i], row_err[i], err);
            if (!row_err[i]) ref_mem[idx] = merge_bytes(ref_mem[idx], row_dat[i], row_sel[i]);
         end
         OP_RD: begin
            xfer(row_core[i], row_adr[i], '0, row_sel[i], 1'b0, got, err);
            check_flag(row_core[i], row_err[i], err);
            if (!row_err[i]) check_word(dat_name(row_core[i]), ref_mem[idx], got);
         end
         OP_CAS: begin
            run_cas(row_core[i], row_adr[i], row_cmp[i], row_dat[i], got, err);
            check_flag(row_core[i], row_err[i], err);
            if (!row_err[i]) begin
               check_word(dat_name(row_core[i]), ref_mem[idx], got);
               if (ref_mem[idx] == row_cmp[i]) ref_mem[idx] = row_dat[i];  // CAS rule.
            end
         end
         OP_DUAL_CAS:    dual_cas(i);
         OP_CAS_RD_LOOP: cas_under_reads(i);
         default: ;
      endcase
   endtask

   task automatic add_row(input int core, input op_e op, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                          input logic [DATA_W-1:0] cmp, input logic err);
      row_core[n_rows] = core;
      row_op[n_rows]   = op;
      row_adr[n_rows]  = adr;
      row_dat[n_rows]  = dat;
      row_sel[n_rows]  = sel;
      row_cmp[n_rows]  = cmp;
      row_err[n_rows]  = err;
      n_rows++;
   endtask

   task automatic build_table();
      logic [DATA_W-1:0] r0, r1, r2, r3, r4;
      r0 = $urandom;
      r1 = $urandom;
      r2 = $urandom;
      r3 = $urandom;
      r4 = $urandom;
      add_row(0, OP_WR, 32'h000, 32'h1122_3344, 4'hF, '0, 1'b0);
      add_row(1, OP_WR, 32'h004, 32'hA5A5_A5A5, 4'hF, '0, 1'b0);
      add_row(0, OP_WR, 32'h008, r0, 4'hF, '0, 1'b0);
      add_row(1, OP_WR, 32'h00C, r2, 4'hF, '0, 1'b0);
      add_row(0, OP_WR, 32'h010, 32'hDEAD_BEEF, 4'hF, '0, 1'b0);
      add_row(1, OP_WR, 32'h000, 32'hFFEE_DDCC, 4'b0101, '0, 1'b0);  // Partial.
      add_row(0, OP_RD, 32'h000, '0, 4'hF, '0, 1'b0);
      add_row(0, OP_WR, 32'h004, 32'h0000_7700, 4'b0010, '0, 1'b0);
      add_row(1, OP_RD, 32'h004, '0, 4'hF, '0, 1'b0);
      add_row(0, OP_RD, 32'h00C, '0, 4'hF, '0, 1'b0);
      add_row(1, OP_CAS, 32'h008, r1, 4'hF, r0, 1'b0);               // Match.
      add_row(0, OP_RD, 32'h008, '0, 4'hF, '0, 1'b0);
      add_row(0, OP_CAS, 32'h004, 32'hCAFE_F00D, 4'hF, 32'h1234_5678, 1'b0);
      add_row(1, OP_RD, 32'h004, '0, 4'hF, '0, 1'b0);
      add_row(0, OP_WR, 32'h014, 32'h0000_0100, 4'hF, '0, 1'b0);
      add_row(0, OP_DUAL_CAS, 32'h014, 32'h0000_0200, 4'hF, 32'h0000_0100, 1'b0);
      // Out-of-range rows alias word 0x010.
      add_row(0, OP_WR, 32'h0000_0410, 32'h0BAD_BEEF, 4'hF, '0, 1'b1);
      add_row(1, OP_RD, 32'h0000_0810, '0, 4'hF, '0, 1'b1);
      add_row(1, OP_CAS, 32'h4000_0010, 32'h0000_0000, 4'hF, 32'hDEAD_BEEF, 1'b1);
      add_row(0, OP_RD, 32'h010, '0, 4'hF, '0, 1'b0);
      add_row(1, OP_WR, 32'h01C, r3, 4'hF, '0, 1'b0);
      add_row(0, OP_WR, 32'h018, 32'h5555_AAAA, 4'hF, '0, 1'b0);
      add_row(0, OP_CAS_RD_LOOP, 32'h018, r4, 4'hF, 32'h5555_AAAA, 1'b0);
      add_row(1, OP_RD, 32'h018, '0, 4'hF, '0, 1'b0);
   endtask

   initial begin : main
      logic [31:0] seed_ret;
      core0_adr   = '0;
      core0_dat_w = '0;
      core0_sel   = '0;
      core0_we    = 1'b0;
      core0_cyc   = 1'b0;
      core0_stb   = 1'b0;
      core1_adr   = '0;
      core1_dat_w = '0;
      core1_sel   = '0;
      core1_we    = 1'b0;
      core1_cyc   = 1'b0;
      core1_stb   = 1'b0;
      rst_n       = 1'b0;
      seed_ret    = $urandom(32'hbb409fbd);   // Seeds the generator once.
      build_table();
      table_ready = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         apply_row(i);
      end
      if (error_count == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         $display("TESTS FAILED");
         $fatal(1, "Checks reported errors.");
      end
   end

   initial begin : watchdog
      wait (table_ready);
      repeat (RST_CYCLES + n_rows * ROW_CYCLES) @(posedge clk);
      $display("Timeout: the stimulus table did not complete within %0d cycles.",
               RST_CYCLES + n_rows * ROW_CYCLES);
      report_failure();
   end

endmodule

// File: verilog.f
source/cas_pkg.sv
source/wb_cas_fsm.sv
source/wb_cas_unit.sv
source/wb_arbiter.sv
source/wb_ram.sv
source/cas_smp_top.sv
tb/tb_clkgen.sv
tb/tb_cas_smp.sv
